/* src/mpu_pkg.sv */
// Shared types and the fixed PMA region table for the data-side MPU path
// The table holds three regions, so PMA_NUM_REGIONS must not exceed 3
// Region bounds are inclusive word addresses (byte address bits 31:2)

package mpu_pkg;

  ////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////
  typedef logic [31:0] addr_t;
  typedef logic [29:0] word_addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  // Bit 0 bufferable, bit 1 cacheable
  typedef logic [1:0]  memtype_t;

  // Core and bus request, memtype is zero from the core
  typedef struct packed {
    addr_t    addr;
    logic     we;
    be_t      be;
    data_t    wdata;
    logic     dbg;
    memtype_t memtype;
  } mpu_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_resp_t;

  typedef enum logic [1:0] {
    MPU_OK,
    MPU_RE_FAULT,
    MPU_WR_FAULT
  } mpu_status_e;

  typedef struct packed {
    bus_resp_t   bus_resp;
    mpu_status_e mpu_status;
  } core_resp_t;

  // Error FSM of the protection gate
  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_RE_ERR_WAIT,
    MPU_WR_ERR_WAIT,
    MPU_RE_ERR_RESP,
    MPU_WR_ERR_RESP
  } mpu_state_e;

  typedef struct packed {
    word_addr_t word_addr_low;
    word_addr_t word_addr_high;
    logic       main;
    logic       writable;
    logic       bufferable;
    logic       cacheable;
  } pma_cfg_t;

  ////////////////////////////////////////
  // Default region table
  ////////////////////////////////////////
  // 0: RAM, 1: I/O, 2: ROM
  localparam pma_cfg_t PMA_CFG_DEFAULT [3] = '{
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_003F,
      main: 1'b1, writable: 1'b1, bufferable: 1'b1, cacheable: 1'b1},
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_003F,
      main: 1'b0, writable: 1'b1, bufferable: 1'b0, cacheable: 1'b0},
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0800_003F,
      main: 1'b1, writable: 1'b0, bufferable: 1'b0, cacheable: 1'b0}
  };

  // Debug module window, legal only with dbg set
  localparam addr_t DM_REGION_START = 32'hF000_0000;
  localparam addr_t DM_REGION_END   = 32'hF000_3FFF;

endpackage

/* src/mpu_pma.sv */
// Combinational PMA lookup for one data request, lowest matching region wins
// Uses the first PMA_NUM_REGIONS entries of the default table (at most 3)
// Misaligned here means be neither all ones nor a single byte

`timescale 1ns/1ps

module mpu_pma #(
  parameter int PMA_NUM_REGIONS = 3
) (
  input  mpu_pkg::addr_t trans_addr_i,
  input  logic           trans_we_i,
  input  mpu_pkg::be_t   trans_be_i,
  input  logic           trans_debug_region_i,
  output logic           pma_err_o,
  output logic           pma_bufferable_o,
  output logic           pma_cacheable_o
);

  mpu_pkg::word_addr_t word_addr;
  mpu_pkg::pma_cfg_t   region;
  logic                hit;
  logic                misaligned;

  assign word_addr  = trans_addr_i[31:2];
  assign misaligned = !((trans_be_i == 4'b1111) || $onehot(trans_be_i));

  // Region search, walking down so the lowest index is the last to win
  always_comb begin
    hit    = 1'b0;
    region = '0;
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((word_addr >= mpu_pkg::PMA_CFG_DEFAULT[i].word_addr_low) &&
          (word_addr <= mpu_pkg::PMA_CFG_DEFAULT[i].word_addr_high)) begin
        hit    = 1'b1;
        region = mpu_pkg::PMA_CFG_DEFAULT[i];
      end
    end
  end

  // Attribute and rule check
  always_comb begin
    if (trans_debug_region_i) begin
      // Debug window behaves as legal non-cacheable I/O
      pma_err_o        = 1'b0;
      pma_bufferable_o = 1'b0;
      pma_cacheable_o  = 1'b0;
    end else if (!hit) begin
      pma_err_o        = 1'b1;
      pma_bufferable_o = 1'b0;
      pma_cacheable_o  = 1'b0;
    end else begin
      // Write to read-only, or misaligned in non-main memory
      pma_err_o        = (trans_we_i && !region.writable) || (!region.main && misaligned);
      pma_bufferable_o = region.bufferable;
      pma_cacheable_o  = region.cacheable;
    end
  end

endmodule

/* src/mpu_gate.sv */
// Protection gate between core and data bus, the bus is assumed always ready
// Failing requests are consumed and answered only after older requests return
// one_txn_pend_n_i must predict exactly one outstanding request next cycle

`timescale 1ns/1ps

module mpu_gate #(
  parameter int PMA_NUM_REGIONS = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // Core request channel
  input  logic                 core_trans_valid_i,
  input  mpu_pkg::mpu_req_t    core_trans_i,
  output logic                 core_trans_ready_o,
  // Bus request channel
  output logic                 bus_trans_valid_o,
  output mpu_pkg::mpu_req_t    bus_trans_o,
  // Bus response
  input  logic                 bus_resp_valid_i,
  input  mpu_pkg::bus_resp_t   bus_resp_i,
  // Core response
  output logic                 core_resp_valid_o,
  output mpu_pkg::core_resp_t  core_resp_o,
  input  logic                 one_txn_pend_n_i,
  output logic                 core_mpu_err_o
);

  mpu_pkg::mpu_state_e  state_q;
  mpu_pkg::mpu_state_e  state_n;
  mpu_pkg::mpu_status_e mpu_status;
  logic                 pma_err;
  logic                 pma_bufferable;
  logic                 pma_cacheable;
  logic                 debug_region;
  logic                 block_core;
  logic                 block_bus;
  logic                 err_resp_valid;

  // Debug mode access into the debug module window
  assign debug_region = core_trans_i.dbg &&
                        (core_trans_i.addr >= mpu_pkg::DM_REGION_START) &&
                        (core_trans_i.addr <= mpu_pkg::DM_REGION_END);

  mpu_pma #(
    .PMA_NUM_REGIONS      (PMA_NUM_REGIONS)
  ) pma_i (
    .trans_addr_i         (core_trans_i.addr),
    .trans_we_i           (core_trans_i.we),
    .trans_be_i           (core_trans_i.be),
    .trans_debug_region_i (debug_region),
    .pma_err_o            (pma_err),
    .pma_bufferable_o     (pma_bufferable),
    .pma_cacheable_o      (pma_cacheable)
  );

  ////////////////////////////////////////
  // Error FSM
  ////////////////////////////////////////
  always_comb begin
    state_n        = state_q;
    mpu_status     = mpu_pkg::MPU_OK;
    block_core     = 1'b0;
    block_bus      = 1'b0;
    err_resp_valid = 1'b0;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (pma_err && core_trans_valid_i) begin
          // Accepted here but kept off the bus
          block_bus = 1'b1;
          if (core_trans_i.we) begin
            state_n = one_txn_pend_n_i ? mpu_pkg::MPU_WR_ERR_RESP : mpu_pkg::MPU_WR_ERR_WAIT;
          end else begin
            state_n = one_txn_pend_n_i ? mpu_pkg::MPU_RE_ERR_RESP : mpu_pkg::MPU_RE_ERR_WAIT;
          end
        end
      end
      mpu_pkg::MPU_RE_ERR_WAIT, mpu_pkg::MPU_WR_ERR_WAIT: begin
        // Older requests still in flight
        block_bus  = 1'b1;
        block_core = 1'b1;
        if (one_txn_pend_n_i) begin
          state_n = (state_q == mpu_pkg::MPU_RE_ERR_WAIT) ? mpu_pkg::MPU_RE_ERR_RESP :
                                                            mpu_pkg::MPU_WR_ERR_RESP;
        end
      end
      mpu_pkg::MPU_RE_ERR_RESP, mpu_pkg::MPU_WR_ERR_RESP: begin
        block_bus      = 1'b1;
        block_core     = 1'b1;
        err_resp_valid = 1'b1;
        mpu_status     = (state_q == mpu_pkg::MPU_RE_ERR_RESP) ? mpu_pkg::MPU_RE_FAULT :
                                                                 mpu_pkg::MPU_WR_FAULT;
        // Core always takes the response
        state_n        = mpu_pkg::MPU_IDLE;
      end
      default: state_n = mpu_pkg::MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // Forward path, zero cycles, memtype stamped from the PMA
  assign bus_trans_valid_o = core_trans_valid_i && !block_bus;
  always_comb begin
    bus_trans_o         = core_trans_i;
    bus_trans_o.memtype = {pma_cacheable, pma_bufferable};
  end

  // Ready covers both forwarded and consumed requests
  assign core_trans_ready_o = core_trans_valid_i && !block_core;

  // Bus and fault responses never overlap
  assign core_resp_valid_o      = bus_resp_valid_i || err_resp_valid;
  assign core_resp_o.bus_resp   = err_resp_valid ? '0 : bus_resp_i;
  assign core_resp_o.mpu_status = mpu_status;

  assign core_mpu_err_o = pma_err;

endmodule

/* src/mpu_txn_tracker.sv */
// Outstanding request counter seen from the core side, at most 3 pending
// The output is a look-ahead on the count after this cycle's handshakes

`timescale 1ns/1ps

module mpu_txn_tracker (
  input  logic clk,
  input  logic rst_n,
  input  logic req_fire_i,
  input  logic resp_fire_i,
  output logic one_txn_pend_n_o
);

  logic [1:0] cnt_q;
  logic [1:0] cnt_n;

  // Simultaneous request and response leave the count as is
  always_comb begin
    cnt_n = cnt_q;
    case ({req_fire_i, resp_fire_i})
      2'b10:   cnt_n = cnt_q + 2'd1;
      2'b01:   cnt_n = cnt_q - 2'd1;
      default: cnt_n = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  assign one_txn_pend_n_o = (cnt_n == 2'd1);

endmodule

/* src/mpu_data_mem.sv */
// 64-word data memory slave, always ready, fixed two-cycle response
// Only address bits 7:2 index the array, so all regions alias onto it
// err is never set, writes answer with zero data

`timescale 1ns/1ps

module mpu_data_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  mpu_pkg::mpu_req_t  req_i,
  output logic               resp_valid_o,
  output mpu_pkg::bus_resp_t resp_o
);

  localparam int MEM_WORDS = 64;

  mpu_pkg::data_t mem_q [MEM_WORDS];
  logic [5:0]     idx;
  logic           s1_valid_q;
  logic           s2_valid_q;
  mpu_pkg::data_t s1_rdata_q;
  mpu_pkg::data_t s2_rdata_q;

  assign idx = req_i.addr[7:2];

  ////////////////////////////////////////
  // Storage with byte-enable merge
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (req_valid_i && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Response pipeline
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Read sampled at acceptance, so earlier writes are visible
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      s1_rdata_q <= req_i.we ? '0 : mem_q[idx];
    end
    s2_rdata_q <= s1_rdata_q;
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_o.rdata = s2_rdata_q;
  assign resp_o.err   = 1'b0;

endmodule

/* src/mpu_subsys_top.sv */
// Data-side MPU subsystem: protection gate, request tracker and data memory
// The core must always accept responses and hold a request until ready

`timescale 1ns/1ps

module mpu_subsys_top #(
  parameter int PMA_NUM_REGIONS = 3
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                core_trans_valid_i,
  input  mpu_pkg::mpu_req_t   core_trans_i,
  output logic                core_trans_ready_o,
  output logic                core_resp_valid_o,
  output mpu_pkg::core_resp_t core_resp_o,
  output logic                core_mpu_err_o
);

  logic               bus_trans_valid;
  mpu_pkg::mpu_req_t  bus_trans;
  logic               bus_resp_valid;
  mpu_pkg::bus_resp_t bus_resp;
  logic               one_txn_pend_n;
  logic               req_fire;
  logic               resp_fire;

  // Handshakes seen by the tracker
  assign req_fire  = core_trans_valid_i && core_trans_ready_o;
  assign resp_fire = core_resp_valid_o;

  mpu_gate #(
    .PMA_NUM_REGIONS    (PMA_NUM_REGIONS)
  ) gate_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_i       (core_trans_i),
    .core_trans_ready_o (core_trans_ready_o),
    .bus_trans_valid_o  (bus_trans_valid),
    .bus_trans_o        (bus_trans),
    .bus_resp_valid_i   (bus_resp_valid),
    .bus_resp_i         (bus_resp),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .one_txn_pend_n_i   (one_txn_pend_n),
    .core_mpu_err_o     (core_mpu_err_o)
  );

  mpu_txn_tracker tracker_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_fire_i       (req_fire),
    .resp_fire_i      (resp_fire),
    .one_txn_pend_n_o (one_txn_pend_n)
  );

  mpu_data_mem mem_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (bus_trans_valid),
    .req_i        (bus_trans),
    .resp_valid_o (bus_resp_valid),
    .resp_o       (bus_resp)
  );

endmodule

/* sim/mpu_assert.sv */
// Protocol checks on the protection gate, attached to every mpu_gate by bind
// Assumes the core holds a stalled request unchanged

`timescale 1ns/1ps

module mpu_assert (
  input logic                clk,
  input logic                rst_n,
  input mpu_pkg::mpu_state_e state_i,
  input logic                bus_valid_i,
  input logic                core_valid_i,
  input logic                core_ready_i,
  input mpu_pkg::mpu_req_t   core_req_i
);

  logic in_resp;

  assign in_resp = (state_i == mpu_pkg::MPU_RE_ERR_RESP) ||
                   (state_i == mpu_pkg::MPU_WR_ERR_RESP);

  // No bus traffic outside idle
  bus_idle_only: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i != mpu_pkg::MPU_IDLE) |-> !bus_valid_i)
    else $error("bus request raised outside MPU_IDLE");

  // Stalled request must hold still
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (core_valid_i && !core_ready_i) |=> $stable(core_req_i))
    else $error("core request changed while stalled");

  // Fault response lasts one cycle
  resp_single: assert property (@(posedge clk) disable iff (!rst_n)
    in_resp |=> !in_resp)
    else $error("error FSM stayed in a RESP state for two cycles");

endmodule

bind mpu_gate mpu_assert assert_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .state_i      (state_q),
  .bus_valid_i  (bus_trans_valid_o),
  .core_valid_i (core_trans_valid_i),
  .core_ready_i (core_trans_ready_o),
  .core_req_i   (core_trans_i)
);

/* sim/mpu_tb.sv */
// Directed testbench for the data-side MPU subsystem
// Reference model predicts status, data and latency from the region rules
// Responses are checked in order and inputs change only on the falling edge

`timescale 1ns/1ps

module mpu_tb;

  localparam int CLK_NS     = 10;
  localparam int RST_CYCLES = 4;
  // Directed requests plus the random stream
  localparam int REQ_TOTAL  = 216;
  localparam int LIMIT_NS   = (RST_CYCLES + 200 * REQ_TOTAL) * CLK_NS;

  // Expected core response with the cycle it is due in (0 means any cycle)
  typedef struct packed {
    mpu_pkg::mpu_status_e status;
    mpu_pkg::data_t       rdata;
    logic [31:0]          due;
  } exp_resp_t;

  logic                clk;
  logic                rst_n;
  logic                core_trans_valid_i;
  mpu_pkg::mpu_req_t   core_trans_i;
  logic                core_trans_ready_o;
  logic                core_resp_valid_o;
  mpu_pkg::core_resp_t core_resp_o;
  logic                core_mpu_err_o;

  exp_resp_t           exp_q [$];
  exp_resp_t           head;
  mpu_pkg::data_t      shadow [64];
  logic [31:0]         cyc;
  logic [31:0]         rng_state;
  logic                fault_pending;
  logic                exp_err;
  int                  mismatch_cnt;
  int                  other_cnt;

  mpu_subsys_top #(
    .PMA_NUM_REGIONS    (3)
  ) dut_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_i       (core_trans_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .core_mpu_err_o     (core_mpu_err_o)
  );

  always #(CLK_NS / 2) clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift(rng_state);
    r = rng_state;
  endtask

  // RAM, I/O and ROM windows span 256 bytes each and the debug window needs dbg
  function automatic mpu_pkg::mpu_status_e expect_status(input mpu_pkg::mpu_req_t req);
    logic in_ram;
    logic in_io;
    logic in_rom;
    logic in_dm;
    logic simple_be;
    logic ok;
    in_ram    = (req.addr <= 32'h0000_00FF);
    in_io     = (req.addr >= 32'h1000_0000) && (req.addr <= 32'h1000_00FF);
    in_rom    = (req.addr >= 32'h2000_0000) && (req.addr <= 32'h2000_00FF);
    in_dm     = req.dbg && (req.addr >= 32'hF000_0000) && (req.addr <= 32'hF000_3FFF);
    simple_be = (req.be == 4'hF) || (req.be == 4'h1) || (req.be == 4'h2) ||
                (req.be == 4'h4) || (req.be == 4'h8);
    if (in_dm || in_ram) begin
      ok = 1'b1;
    end else if (in_io) begin
      ok = simple_be;
    end else if (in_rom) begin
      ok = !req.we;
    end else begin
      ok = 1'b0;
    end
    if (ok) begin
      return mpu_pkg::MPU_OK;
    end
    return req.we ? mpu_pkg::MPU_WR_FAULT : mpu_pkg::MPU_RE_FAULT;
  endfunction

  // Push the expected answer and update the shadow memory
  task automatic record_accept(input mpu_pkg::mpu_req_t req);
    exp_resp_t  e;
    logic [5:0] idx;
    idx      = req.addr[7:2];
    e.status = expect_status(req);
    e.rdata  = '0;
    if (e.status == mpu_pkg::MPU_OK) begin
      e.due = cyc + 32'd2;
      if (req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req.be[b]) begin
            shadow[idx][8*b +: 8] = req.wdata[8*b +: 8];
          end
        end
      end else begin
        e.rdata = shadow[idx];
      end
    end else begin
      // One cycle only when nothing older is still in flight
      e.due         = (exp_q.size() == 0) ? cyc + 32'd1 : 32'd0;
      fault_pending = 1'b1;
    end
    exp_q.push_back(e);
  endtask

  ////////////////////////////////////////
  // Monitor sampling at the rising edge
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 32'd1;
      if (core_trans_valid_i) begin
        exp_err = (expect_status(core_trans_i) != mpu_pkg::MPU_OK);
        assert (core_mpu_err_o == exp_err) else begin
          mismatch_cnt++;
          $display("Mismatch at %0t: core_mpu_err_o got %0b expected %0b",
                   $time, core_mpu_err_o, exp_err);
        end
      end
      // Core stays blocked until the fault has been answered
      if (fault_pending && core_trans_valid_i) begin
        assert (!core_trans_ready_o) else begin
          other_cnt++;
          $display("Error at %0t: request accepted before the fault response", $time);
        end
      end
      if (core_resp_valid_o) begin
        if (exp_q.size() == 0) begin
          other_cnt++;
          $display("Error at %0t: response with no request outstanding", $time);
        end else begin
          head = exp_q.pop_front();
          assert (core_resp_o.mpu_status == head.status) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: core_resp_o.mpu_status got %0d expected %0d",
                     $time, core_resp_o.mpu_status, head.status);
          end
          assert (core_resp_o.bus_resp.rdata == head.rdata) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: core_resp_o.bus_resp.rdata got %h expected %h",
                     $time, core_resp_o.bus_resp.rdata, head.rdata);
          end
          // Memory never flags a bus error and fault responses carry a zero bus part
          assert (core_resp_o.bus_resp.err == 1'b0) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: core_resp_o.bus_resp.err got %0b expected 0",
                     $time, core_resp_o.bus_resp.err);
          end
          if (head.due != 32'd0) begin
            assert (cyc == head.due) else begin
              other_cnt++;
              $display("Error at %0t: response came in cycle %0d instead of cycle %0d",
                       $time, cyc, head.due);
            end
          end
          if (head.status != mpu_pkg::MPU_OK) begin
            fault_pending = 1'b0;
          end
        end
      end
      if (core_trans_valid_i && core_trans_ready_o) begin
        record_accept(core_trans_i);
      end
    end
  end

  ////////////////////////////////////////
  // Driver helpers
  ////////////////////////////////////////
  function automatic mpu_pkg::mpu_req_t make_req(input logic [31:0] addr, input logic we,
                                                 input logic [3:0] be, input logic [31:0] wdata,
                                                 input logic dbg);
    mpu_pkg::mpu_req_t req;
    req.addr    = addr;
    req.we      = we;
    req.be      = be;
    req.wdata   = wdata;
    req.dbg     = dbg;
    req.memtype = '0;
    return req;
  endfunction

  // Present a request and hold it until the handshake
  task automatic issue(input mpu_pkg::mpu_req_t req);
    @(negedge clk);
    core_trans_valid_i = 1'b1;
    core_trans_i       = req;
    @(posedge clk);
    while (!core_trans_ready_o) @(posedge clk);
  endtask

  task automatic release_bus();
    @(negedge clk);
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
  endtask

  task automatic drain();
    release_bus();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic ram_write_read();
    issue(make_req(32'h0000_0020, 1'b1, 4'b1111, 32'hA5A5_1234, 1'b0));
    issue(make_req(32'h0000_0020, 1'b1, 4'b0110, 32'hFFEE_DDCC, 1'b0));
    issue(make_req(32'h0000_0020, 1'b0, 4'b1111, 32'h0, 1'b0));
    drain();
  endtask

  // ROM write and unmapped read leave the aliased word untouched
  task automatic rom_and_unmapped_faults();
    issue(make_req(32'h2000_0008, 1'b1, 4'b1111, 32'hDEAD_BEEF, 1'b0));
    drain();
    issue(make_req(32'h3000_0000, 1'b0, 4'b1111, 32'h0, 1'b0));
    drain();
    issue(make_req(32'h0000_0008, 1'b0, 4'b1111, 32'h0, 1'b0));
    drain();
  endtask

  // The trailing read waits behind the fault
  task automatic fault_ordering();
    issue(make_req(32'h0000_0020, 1'b0, 4'b1111, 32'h0, 1'b0));
    issue(make_req(32'h0000_0024, 1'b0, 4'b1111, 32'h0, 1'b0));
    issue(make_req(32'h2000_0000, 1'b1, 4'b1111, 32'h1111_2222, 1'b0));
    issue(make_req(32'h0000_0020, 1'b0, 4'b1111, 32'h0, 1'b0));
    drain();
  endtask

  task automatic io_misalign();
    issue(make_req(32'h1000_0004, 1'b1, 4'b0100, 32'h0055_0000, 1'b0));
    issue(make_req(32'h1000_0008, 1'b1, 4'b0011, 32'h0000_7788, 1'b0));
    issue(make_req(32'h0000_0008, 1'b1, 4'b0011, 32'h0000_7788, 1'b0));
    drain();
  endtask

  task automatic debug_window();
    issue(make_req(32'h0000_0010, 1'b1, 4'b1111, 32'h1357_9BDF, 1'b0));
    issue(make_req(32'hF000_0010, 1'b0, 4'b1111, 32'h0, 1'b1));
    issue(make_req(32'hF000_0010, 1'b0, 4'b1111, 32'h0, 1'b0));
    drain();
  endtask

  // Regions, gaps and debug window with random fields and idle gaps
  task automatic random_stream();
    logic [31:0]       r;
    logic [31:0]       base;
    mpu_pkg::mpu_req_t req;
    for (int n = 0; n < 200; n++) begin
      next_rand(r);
      case (r[2:0])
        3'd0, 3'd1: base = 32'h0000_0000;
        3'd2:       base = 32'h1000_0000;
        3'd3:       base = 32'h2000_0000;
        3'd4:       base = 32'h0000_0100;
        3'd5:       base = 32'h3000_0000;
        default:    base = 32'hF000_0000;
      endcase
      req = make_req(base | {24'd0, r[15:10], 2'b00}, r[3], r[7:4], 32'h0, r[8]);
      next_rand(r);
      req.wdata = r;
      issue(req);
      next_rand(r);
      if (r[1]) begin
        release_bus();
        repeat (r[3:2]) @(negedge clk);
      end
    end
    drain();
  endtask

  // Watchdog
  initial begin
    #(LIMIT_NS);
    $display("Error: simulation timed out after %0d ns", LIMIT_NS);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    clk                = 1'b0;
    rst_n              = 1'b0;
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
    cyc                = '0;
    rng_state          = 32'h6a24;
    fault_pending      = 1'b0;
    mismatch_cnt       = 0;
    other_cnt          = 0;
    for (int w = 0; w < 64; w++) begin
      shadow[w] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!core_trans_ready_o && !core_resp_valid_o) else begin
      other_cnt++;
      $display("Error at %0t: ready or response valid high after reset", $time);
    end
    ram_write_read();
    rom_and_unmapped_faults();
    fault_ordering();
    io_misalign();
    debug_window();
    random_stream();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
src/mpu_pkg.sv
src/mpu_pma.sv
src/mpu_gate.sv
src/mpu_txn_tracker.sv
src/mpu_data_mem.sv
src/mpu_subsys_top.sv
sim/mpu_assert.sv
sim/mpu_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the MPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module mpu_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmpu_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the testbench printed the pass line
if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
fi
exit 1
